/* Makefile */
TOP = posit_accum_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* dv/posit_accum_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Credit handshake assertions
// Bound into the input buffer and the output port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module posit_accum_asserts (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [$clog2(accum_pkg::OUT_CREDITS+1)-1:0] credits,
    input  logic                                        out_valid,
    input  logic                                        out_credit,
    input  logic                                        in_credit
);
    import accum_pkg::*;

    int granted;        // Credits held as seen from the consumer side
    int failures = 0;   // Failed assertions so far

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            granted <= OUT_CREDITS;
        else
            granted <= granted - int'(out_valid) + int'(out_credit);
    end

    // A result leaves only with a credit in hand
    valid_needs_credit: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> granted > 0)
    else
    begin
        $error("out_valid high with no output credit");
        failures++;
    end

    credit_limit: assert property (@(posedge clk) disable iff (rst)
        credits <= OUT_CREDITS)
    else
    begin
        $error("Output credit counter above its limit");
        failures++;
    end

    quiet_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !in_credit && !out_valid)  // Flops settled after one edge
    else
    begin
        $error("Handshake output active during reset");
        failures++;
    end

endmodule

bind output_credit_port posit_accum_asserts port_asserts_i (
    .clk        (clk),
    .rst        (rst),
    .credits    (credits),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .in_credit  (1'b0)
);

bind input_credit_buffer posit_accum_asserts buffer_asserts_i (
    .clk        (clk),
    .rst        (rst),
    .credits    ('0),
    .out_valid  (1'b0),
    .out_credit (1'b0),
    .in_credit  (in_credit)
);

`default_nettype wire

/* dv/posit_accum_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Posit accumulator testbench
// Credit-aware random stimulus checked against an exact sum model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module posit_accum_tb;
    import accum_pkg::*;
    import posit_format_pkg::*;

    localparam int N_RANDOM = 200;
    localparam int N_RESTART = 60;
    localparam int N_NAR = 40;
    localparam int N_CANCEL = 20;
    localparam int N_STALL = 120;
    localparam int TOTAL_INPUTS = N_RANDOM + N_RESTART + N_NAR + N_CANCEL + N_STALL;
    localparam int CYCLE_LIMIT = TOTAL_INPUTS * 20 + 100;
    localparam posit_t MAXPOS = 16'h7fff;
    localparam posit_t NAR = 16'h8000;

    logic       clk;
    logic       rst;
    logic       in_valid;
    in_item_t   in_item;
    logic       in_credit;
    logic       out_valid;
    result_t    out_result;
    logic       out_credit;

    integer     seed = 32'hd72f_65f3;
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    int         cycles = 0;
    int         in_credits_held;    // Producer side
    int         owed_credits;       // Results taken but not yet credited back
    int         stall_left;
    bit         long_stalls;
    string      test_name;
    int         result_idx;
    in_item_t   stim_q[$];
    result_t    exp_q[$];
    logic signed [ACC_BITS-1:0] model_sum;
    logic       model_nar;

    posit_accum_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_item    (in_item),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_credit (out_credit)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, %0d results never arrived", cycles, exp_q.size());
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Exact value of a posit in the fixed-point format of the sum
    function automatic logic signed [ACC_BITS-1:0] posit_to_fixed(posit_t w);
        posit_t                 a;
        logic                   first;
        int                     p;
        int                     run;
        int                     k;
        int                     e;
        int                     nf;
        logic [ACC_BITS-1:0]    m;
        if (w == '0 || w == NAR)
            return '0;
        a = w[NBITS-1] ? -w : w;
        first = a[NBITS-2];
        run = 0;
        p = NBITS - 2;
        while (p >= 0 && a[p] == first)
        begin
            run++;
            p--;
        end
        p--;                                // Terminator may be cut off
        k = first ? run - 1 : -run;
        e = 0;
        if (p >= 0)
        begin
            e = int'(a[p]);                 // One exponent bit
            p--;
        end
        nf = (p >= 0) ? p + 1 : 0;
        m = ACC_BITS'(1);                   // Hidden bit
        for (int i = p; i >= 0; i--)
            m = {m[ACC_BITS-2:0], a[i]};
        m = m << (k * (1 << ES) + e - nf + ACC_FRAC_BITS);
        return w[NBITS-1] ? -$signed(m) : $signed(m);
    endfunction

    // Encode the exact sum with bit-string rounding to nearest even
    function automatic result_t fixed_to_posit(logic signed [ACC_BITS-1:0] sum, logic nar);
        result_t                r;
        logic                   sign;
        logic [ACC_BITS-1:0]    mag;
        int                     lead;
        int                     s;
        int                     k;
        int                     p;
        logic [127:0]           bits;
        logic [NBITS-2:0]       body;
        r.inf = nar;
        r.zero = !nar && sum == '0;
        r.value = '0;
        if (nar)
            r.value = NAR;
        else if (!r.zero)
        begin
            sign = sum[ACC_BITS-1];
            mag = sign ? -sum : sum;
            lead = 0;
            for (int i = 0; i < ACC_BITS; i++)
            begin
                if (mag[i])
                    lead = i;
            end
            s = lead - ACC_FRAC_BITS;
            if (s > MAX_SCALE)
                body = '1;                  // maxpos
            else if (s < -MAX_SCALE)
                body = (NBITS-1)'(1);       // minpos
            else
            begin
                k = s >>> ES;
                bits = '0;
                p = 127;
                if (k >= 0)
                begin
                    for (int j = 0; j <= k; j++)
                    begin
                        bits[p] = 1'b1;
                        p--;
                    end
                    p--;                    // Zero terminator
                end
                else
                begin
                    p = p + k;              // Run of zeros
                    bits[p] = 1'b1;
                    p--;
                end
                bits[p] = s[0];
                p--;
                for (int i = lead - 1; i >= 0; i--)
                begin
                    bits[p] = mag[i];
                    p--;
                end
                body = bits[127 -: NBITS-1];
                if (bits[128-NBITS] && ((|bits[127-NBITS:0]) || body[0]))
                    body = body + 1'b1;
            end
            r.value = sign ? -{1'b0, body} : {1'b0, body};
        end
        return r;
    endfunction

    function automatic posit_t random_posit();
        posit_t w;
        w = 16'($random(seed));
        if (w == NAR)
            w = 16'h4000;
        return w;
    endfunction

    task automatic queue_input(logic clear, posit_t value);
        in_item_t it;
        logic signed [ACC_BITS-1:0] x;
        it.clear = clear;
        it.value = value;
        stim_q.push_back(it);
        x = posit_to_fixed(value);
        if (clear)
        begin
            model_sum = x;
            model_nar = value == NAR;
        end
        else
        begin
            model_sum = model_sum + x;
            model_nar = model_nar | (value == NAR);
        end
        exp_q.push_back(fixed_to_posit(model_sum, model_nar));
    endtask

    task automatic check_value(string label, result_t expected, result_t actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("MISMATCH %s: expected %h inf=%b zero=%b, actual %h inf=%b zero=%b",
                     label, expected.value, expected.inf, expected.zero,
                     actual.value, actual.inf, actual.zero);
        end
    endtask

    // One clock of producer, consumer and result capture
    task automatic step_cycle();
        result_t expected;
        @(posedge clk);
        #1;
        if (in_credit)
        begin
            in_credits_held++;
            if (in_credits_held > IN_CREDITS)
            begin
                errors++;
                $display("Producer got back %0d input credits, more than were granted",
                         in_credits_held);
            end
        end
        if (out_valid)
        begin
            owed_credits++;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("Result %h arrived with no input outstanding", out_result.value);
            end
            else
            begin
                expected = exp_q.pop_front();
                check_value($sformatf("%s result %0d", test_name, result_idx), expected,
                            out_result);
                result_idx++;
            end
        end
        out_credit = 1'b0;
        if (stall_left > 0)
            stall_left--;
        else if (owed_credits > 0)
        begin
            if (long_stalls && ($random(seed) & 7) == 0)
                stall_left = 10 + ($random(seed) & 31);
            else if (long_stalls || ($random(seed) & 3) != 0)
            begin
                out_credit = 1'b1;
                owed_credits--;
            end
        end
        in_valid = 1'b0;
        if (stim_q.size() > 0 && in_credits_held > 0 && ($random(seed) & 3) != 0)
        begin
            in_item = stim_q.pop_front();
            in_valid = 1'b1;
            in_credits_held--;
        end
    endtask

    task automatic run_test(string name);
        int first_error;
        test_name = name;
        result_idx = 0;
        first_error = errors;
        while (stim_q.size() > 0 || exp_q.size() > 0)
            step_cycle();
        tests++;
        $display("%s: %0d results, %0d errors", name, result_idx, errors - first_error);
    endtask

    initial
    begin
        posit_t x;
        rst = 1'b1;
        in_valid = 1'b0;
        in_item = '0;
        out_credit = 1'b0;
        in_credits_held = IN_CREDITS;
        owed_credits = 0;
        stall_left = 0;
        long_stalls = 1'b0;
        model_sum = '0;
        model_nar = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < N_RANDOM; i++)
            queue_input(i == 0, random_posit());
        run_test("random_sum");

        for (int i = 0; i < N_RESTART; i++)
            queue_input(i == 0 || i == N_RESTART / 2, random_posit());
        run_test("mid_clear");

        // NaR at 10, a clear with NaR at 20 keeps it, a clear at 30 ends it
        for (int i = 0; i < N_NAR; i++)
            queue_input(i == 0 || i == 20 || i == 30,
                        (i == 10 || i == 20) ? NAR : random_posit());
        run_test("nar_sticky");

        for (int i = 0; i < N_CANCEL / 4; i++)
        begin
            x = random_posit();
            queue_input(1'b1, x);
            queue_input(1'b0, -x);
        end
        queue_input(1'b1, MAXPOS);
        for (int i = 1; i < N_CANCEL / 2; i++)
            queue_input(1'b0, MAXPOS);
        run_test("cancel_maxpos");

        long_stalls = 1'b1;
        for (int i = 0; i < N_STALL; i++)
            queue_input(i == 0, random_posit());
        run_test("credit_stall");
        long_stalls = 1'b0;

        // Drain so that all input credits return and nothing more comes out
        repeat (30) step_cycle();
        if (in_credits_held != IN_CREDITS)
        begin
            errors++;
            $display("Producer ended with %0d input credits instead of %0d",
                     in_credits_held, IN_CREDITS);
        end

        // Failed bound assertions count as errors
        errors += dut_i.out_port_i.port_asserts_i.failures
                  + dut_i.buffer_i.buffer_asserts_i.failures;

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hdl/posit_format_pkg.sv
hdl/accum_pkg.sv
hdl/input_credit_buffer.sv
hdl/posit_decode_stage.sv
hdl/align_accumulate_stage.sv
hdl/normalize_round_stage.sv
hdl/output_credit_port.sv
hdl/posit_accum_top.sv
dv/posit_accum_asserts.sv
dv/posit_accum_tb.sv

/* hdl/accum_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Accumulator package
// Sum width, credit counts and the items passed between stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package accum_pkg;

    // Fixed-point running sum
    // Scales span -28..28, so 42 fractional bits keep every input exact
    localparam int ACC_BITS = 80;
    localparam int ACC_FRAC_BITS = 42;

    localparam int IN_CREDITS = 2;   // Input buffer depth
    localparam int OUT_CREDITS = 4;  // Credits granted by the consumer after reset

    // One input transfer
    typedef struct packed {
        logic                       clear; // Start a new sum with this value
        posit_format_pkg::posit_t   value;
    } in_item_t;

    // Decode stage output
    typedef struct packed {
        logic                       clear;
        posit_format_pkg::unpacked_t num;
    } dec_item_t;

    // Running sum after an input was added
    typedef struct packed {
        logic                       nar;   // Sticky until the next clear
        logic signed [ACC_BITS-1:0] sum;
    } acc_item_t;

    // Rounded result
    typedef struct packed {
        posit_format_pkg::posit_t   value;
        logic                       inf;
        logic                       zero;
    } result_t;

endpackage

`default_nettype wire

/* hdl/align_accumulate_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Align and accumulate stage
// Converts a decoded posit to fixed point and adds it to the sum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module align_accumulate_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    input  logic                    dec_valid,
    input  accum_pkg::dec_item_t    dec_item,
    output logic                    acc_valid,
    output accum_pkg::acc_item_t    acc_item
);
    import accum_pkg::*;
    import posit_format_pkg::*;

    // Shift that puts a scale-0 hidden bit on the binary point
    localparam int BASE_SHIFT = ACC_FRAC_BITS - FRAC_BITS;

    logic [6:0]                 shamt;
    logic [ACC_BITS-1:0]        mag;
    logic signed [ACC_BITS-1:0] addend;
    logic signed [ACC_BITS-1:0] sum_next;
    logic                       nar_next;

    // Scale -28 gives 2, scale 28 gives 58
    assign shamt = 7'(int'(dec_item.num.scale) + BASE_SHIFT);
    assign mag = ACC_BITS'({1'b1, dec_item.num.frac}) << shamt;

    always_comb
    begin
        if (dec_item.num.zero || dec_item.num.nar)
            addend = '0;
        else if (dec_item.num.sign)
            addend = -$signed(mag);
        else
            addend = $signed(mag);
    end

    // Clear loads the input, otherwise add into the running sum
    assign sum_next = dec_item.clear ? addend : acc_item.sum + addend;
    assign nar_next = dec_item.clear ? dec_item.num.nar : acc_item.nar | dec_item.num.nar;

    // The sum register is the stage output, so the add loop is one cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            acc_valid <= 1'b0;
            acc_item.nar <= 1'b0;
            acc_item.sum <= '0;
        end
        else if (advance)
        begin
            acc_valid <= dec_valid;
            if (dec_valid)
            begin
                acc_item.nar <= nar_next;
                acc_item.sum <= sum_next;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/input_credit_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input credit buffer
// Small FIFO that returns a credit for every item released
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module input_credit_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  accum_pkg::in_item_t in_item,
    output logic                in_credit,
    input  logic                advance,
    output logic                buf_valid,
    output accum_pkg::in_item_t buf_item
);
    import accum_pkg::*;

    // Depth equals the producer's credits, a power of two so pointers wrap
    localparam int PW = $clog2(IN_CREDITS);

    in_item_t       mem [IN_CREDITS];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [PW:0]    count;
    logic           pop;

    assign buf_valid = count != '0;
    assign buf_item = mem[rd_ptr];     // Oldest entry
    assign pop = advance && buf_valid; // Decode stage takes it this edge

    always_ff @(posedge clk)
    begin
        if (in_valid)
            mem[wr_ptr] <= in_item;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in_credit <= 1'b0;
        end
        else
        begin
            if (in_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PW + 1)'(in_valid) - (PW + 1)'(pop);
            in_credit <= pop; // One pulse per released item
        end
    end

endmodule

`default_nettype wire

/* hdl/normalize_round_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Normalize and round stage
// Encodes the fixed-point sum as a posit, round to nearest even
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module normalize_round_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    input  logic                    acc_valid,
    input  accum_pkg::acc_item_t    acc_item,
    output logic                    norm_valid,
    output accum_pkg::result_t      norm_result
);
    import accum_pkg::*;
    import posit_format_pkg::*;

    localparam int FT = NBITS - 1 - ES;  // Fraction bits kept ahead of the sticky OR
    localparam int YW = 2 * NBITS;       // Regime fill, terminator, exponent, fraction
    localparam int BW = NBITS - 1;       // Encoded bits without the sign

    logic                   sign;
    logic [ACC_BITS-1:0]    mag;
    logic [6:0]             lead;
    logic [ACC_BITS-1:0]    norm;
    logic [FT-1:0]          frac_top;
    logic                   sticky_low;
    logic signed [7:0]      scale_raw;
    logic signed [7:0]      scale;
    logic signed [7:0]      k;
    logic                   term;
    logic [4:0]             run;
    logic [YW-1:0]          y;
    logic [YW-1:0]          y_shift;
    logic [BW-1:0]          trunc;
    logic                   guard;
    logic                   sticky;
    logic [BW-1:0]          rounded;
    result_t                res;

    assign sign = acc_item.sum[ACC_BITS-1];
    assign mag = sign ? -acc_item.sum : acc_item.sum;

    // Leading one detection
    always_comb
    begin
        lead = '0;
        for (int i = 0; i < ACC_BITS; i++)
        begin
            if (mag[i])
                lead = 7'(i);
        end
    end

    assign norm = mag << (7'(ACC_BITS - 1) - lead);  // Hidden bit to the MSB
    assign frac_top = norm[ACC_BITS-2 -: FT];
    assign sticky_low = |norm[ACC_BITS-2-FT:0];
    assign scale_raw = 8'(lead) - 8'(ACC_FRAC_BITS);

    // Clamped scales encode as maxpos or minpos since their guard is the terminator or e = 0
    always_comb
    begin
        if (scale_raw > MAX_SCALE)
            scale = 8'(MAX_SCALE);
        else if (scale_raw < -MAX_SCALE)
            scale = 8'(-MAX_SCALE);
        else
            scale = scale_raw;
    end

    assign k = scale >>> ES;
    assign term = k < 0;                        // Regime of zeros ends in a one
    assign run = term ? 5'(-k) : 5'(k + 8'sd1);
    assign y = {{NBITS{~term}}, term, scale[ES-1:0], frac_top};
    assign y_shift = y >> run;
    assign trunc = y_shift[BW:1];
    assign guard = y_shift[0];
    assign sticky = |(y & ((YW'(1) << run) - YW'(1))) | sticky_low;
    assign rounded = trunc + BW'(guard & (sticky | trunc[0]));

    always_comb
    begin
        res.inf = acc_item.nar;
        res.zero = !acc_item.nar && acc_item.sum == '0;
        if (res.inf)
            res.value = {1'b1, {NBITS-1{1'b0}}};
        else if (res.zero)
            res.value = '0;
        else
            res.value = sign ? -{1'b0, rounded} : {1'b0, rounded};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            norm_valid <= 1'b0;
        else if (advance)
            norm_valid <= acc_valid;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            norm_result <= res;
    end

endmodule

`default_nettype wire

/* hdl/output_credit_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output credit port
// Result register and credit counter, stalls the pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module output_credit_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                norm_valid,
    input  accum_pkg::result_t  norm_result,
    input  logic                out_credit,
    output logic                advance,
    output logic                out_valid,
    output accum_pkg::result_t  out_result
);
    import accum_pkg::*;

    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0]  credits;
    logic           res_valid;  // Result register is full
    logic           no_credit;

    assign no_credit = credits == '0;
    assign out_valid = res_valid && !no_credit;
    assign advance = !(res_valid && no_credit);  // Hold everything on a stuck result

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            credits <= CW'(OUT_CREDITS);
            res_valid <= 1'b0;
        end
        else
        begin
            credits <= credits - CW'(out_valid) + CW'(out_credit);
            if (advance)
                res_valid <= norm_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            out_result <= norm_result;
    end

endmodule

`default_nettype wire

/* hdl/posit_accum_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Posit accumulator top level
// Credit-based input and output around a three-stage pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module posit_accum_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  accum_pkg::in_item_t     in_item,
    output logic                    in_credit,
    output logic                    out_valid,
    output accum_pkg::result_t      out_result,
    input  logic                    out_credit
);

    logic                   advance;   // Common enable of all stage registers
    logic                   buf_valid;
    accum_pkg::in_item_t    buf_item;
    logic                   dec_valid;
    accum_pkg::dec_item_t   dec_item;
    logic                   acc_valid;
    accum_pkg::acc_item_t   acc_item;
    logic                   norm_valid;
    accum_pkg::result_t     norm_result;

    input_credit_buffer buffer_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_item    (in_item),
        .in_credit  (in_credit),
        .advance    (advance),
        .buf_valid  (buf_valid),
        .buf_item   (buf_item)
    );

    posit_decode_stage decode_i (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .buf_valid  (buf_valid),
        .buf_item   (buf_item),
        .dec_valid  (dec_valid),
        .dec_item   (dec_item)
    );

    align_accumulate_stage accumulate_i (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .dec_valid  (dec_valid),
        .dec_item   (dec_item),
        .acc_valid  (acc_valid),
        .acc_item   (acc_item)
    );

    normalize_round_stage normalize_i (
        .clk         (clk),
        .rst         (rst),
        .advance     (advance),
        .acc_valid   (acc_valid),
        .acc_item    (acc_item),
        .norm_valid  (norm_valid),
        .norm_result (norm_result)
    );

    output_credit_port out_port_i (
        .clk         (clk),
        .rst         (rst),
        .norm_valid  (norm_valid),
        .norm_result (norm_result),
        .out_credit  (out_credit),
        .advance     (advance),
        .out_valid   (out_valid),
        .out_result  (out_result)
    );

endmodule

`default_nettype wire

/* hdl/posit_decode_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Posit decode stage
// Splits a posit word into sign, scale and fraction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module posit_decode_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    input  logic                    buf_valid,
    input  accum_pkg::in_item_t     buf_item,
    output logic                    dec_valid,
    output accum_pkg::dec_item_t    dec_item
);
    import accum_pkg::*;
    import posit_format_pkg::*;

    posit_t             word;
    posit_t             mag_w;
    logic [NBITS-2:0]   body;
    logic [NBITS-2:0]   rest;
    logic               regime_bit;
    logic               run_end;
    logic [4:0]         run;        // Length of the regime run
    logic signed [6:0]  k;
    logic signed [6:0]  scale_full;
    unpacked_t          num;

    assign word = buf_item.value;
    assign mag_w = word[NBITS-1] ? -word : word;  // Negative words decode from their complement
    assign body = mag_w[NBITS-2:0];
    assign regime_bit = body[NBITS-2];

    always_comb
    begin
        run = '0;
        run_end = 1'b0;
        for (int i = NBITS - 2; i >= 0; i--)
        begin
            if (!run_end && body[i] == regime_bit)
                run = run + 1'b1;
            else
                run_end = 1'b1;
        end
    end

    // Drop the run and its terminator, exponent then fraction remain
    assign rest = body << (run + 5'd1);
    assign k = regime_bit ? $signed({2'b00, run}) - 7'sd1 : -$signed({2'b00, run});
    assign scale_full = (k <<< ES) + $signed(7'(rest[NBITS-2 -: ES]));

    assign num.sign = word[NBITS-1];
    assign num.zero = word == '0;
    assign num.nar = word == {1'b1, {NBITS-1{1'b0}}};
    assign num.scale = scale_full[5:0];
    assign num.frac = rest[NBITS-2-ES -: FRAC_BITS];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            dec_valid <= 1'b0;
        else if (advance)
            dec_valid <= buf_valid;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            dec_item.clear <= buf_item.clear;
            dec_item.num <= num;
        end
    end

endmodule

`default_nettype wire

/* hdl/posit_format_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Posit format package
// Word layout of 16-bit posits with one exponent bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package posit_format_pkg;

    localparam int NBITS = 16;      // Posit word width
    localparam int ES = 1;          // Exponent bits
    localparam int MAX_SCALE = 28;  // Scale of maxpos, minpos is its negative

    // Regime takes at least two bits, so this is the widest fraction
    localparam int FRAC_BITS = 12;

    typedef logic [NBITS-1:0] posit_t;

    // Decoded posit
    // The hidden bit is implied and not stored in frac
    typedef struct packed {
        logic                   sign;
        logic                   nar;   // Not a real
        logic                   zero;
        logic signed [5:0]      scale; // 2^ES * k + e
        logic [FRAC_BITS-1:0]   frac;  // Left aligned
    } unpacked_t;

endpackage

`default_nettype wire
